//--- logic/backend_cfg.svh
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// datapath width
`define XLEN 64

// architectural register index
`define LREG_W 5

// memory channel index taken from address bits [21:3]
`define MEM_INDEX_W 19
`define MEM_INDEX_LSB 3

// registered boundaries behind execute (mem, wb)
`define STAGE_CNT 2

`endif

//--- logic/backend_pkg.sv
`include "backend_cfg.svh"

package backend_pkg;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // one-hot access size
    typedef enum logic [3:0] {
        LS_BYTE   = 4'b0001,
        LS_HALF   = 4'b0010,
        LS_WORD   = 4'b0100,
        LS_DOUBLE = 4'b1000
    } ls_size_e;

    typedef struct packed {
        logic [`LREG_W-1:0] rd;
        logic [`XLEN-1:0]   src1;
        logic [`XLEN-1:0]   src2;
        logic [`XLEN-1:0]   imm;
        logic               is_imm;
        logic               is_word;   // 32-bit op with sign-extended result
        alu_op_e            alu_op;
        logic               is_load;
        logic               is_store;
        ls_size_e           ls_size;
        logic               is_unsigned;
        logic               need_to_wb;
    } issue_t;

    typedef struct packed {
        logic [`LREG_W-1:0] rd;
        logic               need_to_wb;
        logic               is_load;
        logic               is_store;
        ls_size_e           ls_size;
        logic               is_unsigned;
        logic [`XLEN-1:0]   alu_result;
        logic [`XLEN-1:0]   ls_address;
        logic [`XLEN-1:0]   store_data;
    } ex_mem_t;

    typedef struct packed {
        logic [`LREG_W-1:0] rd;
        logic               need_to_wb;
        logic [`XLEN-1:0]   result;
    } mem_wb_t;

    typedef struct packed {
        logic [`LREG_W-1:0] rd;
        logic               need_to_wb;
        logic [`XLEN-1:0]   result;
    } byp_t;

    typedef struct packed {
        logic [`MEM_INDEX_W-1:0] index;
        logic [`XLEN-1:0]        write_mask;   // bit mask
        logic [`XLEN-1:0]        write_data;
    } mem_req_t;

endpackage

//--- logic/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     en,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            q <= '0;
        end else if (en) begin
            q <= d;   // hold while the stage is stalled
        end
    end

endmodule

//--- logic/backend_ctrl.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module backend_ctrl (
    input  logic clock,
    input  logic reset_n,
    input  logic pipeval,
    input  logic mem_busy,
    output logic mem_valid,
    output logic wb_valid,
    output logic ex_mem_en,
    output logic mem_stall,
    output logic flop_commit_valid
);

    // [0] memory stage, [STAGE_CNT-1] writeback stage
    logic [`STAGE_CNT-1:0] stage_valid;

    assign mem_stall = mem_busy;
    assign ex_mem_en = ~mem_busy;

    assign mem_valid = stage_valid[0];
    assign wb_valid  = stage_valid[`STAGE_CNT-1];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            stage_valid <= '0;
        end else begin
            if (ex_mem_en) begin
                stage_valid[0] <= pipeval;   // upstream holds issue during a stall
            end
            // mem entry only moves on once its access is done
            stage_valid[`STAGE_CNT-1] <= stage_valid[0] & ~mem_busy;
        end
    end

    // one pulse per retired instruction, stores included
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            flop_commit_valid <= 1'b0;
        end else begin
            flop_commit_valid <= wb_valid;
        end
    end

endmodule

//--- logic/alu_unit.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module alu_unit import backend_pkg::*; (
    input  issue_t  issue,
    input  logic    mem_valid,
    output ex_mem_t ex_out,
    output byp_t    ex_byp
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] raw;
    logic [`XLEN-1:0] alu_result;
    logic [5:0]       shamt;

    assign op_a  = issue.src1;
    assign op_b  = issue.is_imm ? issue.imm : issue.src2;
    assign shamt = issue.is_word ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  raw = op_a + op_b;
            ALU_SUB:  raw = op_a - op_b;
            ALU_AND:  raw = op_a & op_b;
            ALU_OR:   raw = op_a | op_b;
            ALU_XOR:  raw = op_a ^ op_b;
            ALU_SLL:  raw = op_a << shamt;
            // word right shifts work on the low half with zero or sign fill
            ALU_SRL:  raw = issue.is_word ? {32'b0, op_a[31:0]} >> shamt : op_a >> shamt;
            ALU_SRA: begin
                if (issue.is_word) begin
                    raw = $signed({{(`XLEN-32){op_a[31]}}, op_a[31:0]}) >>> shamt;
                end else begin
                    raw = $signed(op_a) >>> shamt;
                end
            end
            ALU_SLT:  raw = `XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: raw = `XLEN'(op_a < op_b);
            default:  raw = '0;
        endcase
    end

    assign alu_result = issue.is_word ? {{(`XLEN-32){raw[31]}}, raw[31:0]} : raw;

    assign ex_out = '{
        rd:          issue.rd,
        need_to_wb:  issue.need_to_wb,
        is_load:     issue.is_load,
        is_store:    issue.is_store,
        ls_size:     issue.ls_size,
        is_unsigned: issue.is_unsigned,
        alu_result:  alu_result,
        ls_address:  issue.src1 + issue.imm,
        store_data:  issue.src2
    };

    // a load result is not known yet in execute
    assign ex_byp = '{
        rd:         issue.rd,
        need_to_wb: mem_valid & issue.need_to_wb & ~issue.is_load & ~issue.is_store,
        result:     alu_result
    };

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module mem_stage import backend_pkg::*; (
    input  logic             clock,
    input  logic             reset_n,
    input  logic             mem_valid,
    input  ex_mem_t          ex_in,
    input  logic             wb_valid,
    input  mem_wb_t          wb_in,
    input  logic             opload_index_ready,
    input  logic [`XLEN-1:0] opload_read_data,
    input  logic             opload_operation_done,
    input  logic             opstore_index_ready,
    input  logic             opstore_operation_done,
    output mem_wb_t          mem_out,
    output byp_t             mem_byp,
    output logic             mem_busy,
    output logic             opload_index_valid,
    output logic             opstore_index_valid,
    output mem_req_t         load_req,
    output mem_req_t         store_req,
    output logic             regfile_write_valid
);

    typedef enum logic {ST_REQ, ST_WAIT} mem_state_e;

    mem_state_e                state;
    logic                      is_mem;
    logic                      index_ready;
    logic                      op_done;
    logic                      req_fire;
    logic                      done_now;
    logic [`MEM_INDEX_LSB-1:0] offset;
    logic [7:0]                byte_mask;
    logic [7:0]                byte_en;
    logic [`XLEN-1:0]          write_mask;
    logic [`XLEN-1:0]          load_shifted;
    logic [`XLEN-1:0]          load_value;

    assign is_mem      = mem_valid & (ex_in.is_load | ex_in.is_store);
    assign index_ready = ex_in.is_load ? opload_index_ready : opstore_index_ready;
    assign op_done     = ex_in.is_load ? opload_operation_done : opstore_operation_done;
    assign req_fire    = is_mem & (state == ST_REQ) & index_ready;
    assign done_now    = is_mem & (state == ST_WAIT) & op_done;
    assign mem_busy    = is_mem & ~done_now;   // low in the done cycle so the entry moves on

    assign opload_index_valid  = is_mem & ex_in.is_load & (state == ST_REQ);
    assign opstore_index_valid = is_mem & ex_in.is_store & (state == ST_REQ);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_REQ;
        end else if (req_fire) begin
            state <= ST_WAIT;
        end else if (done_now) begin
            state <= ST_REQ;
        end
    end

    assign offset = ex_in.ls_address[`MEM_INDEX_LSB-1:0];

    always_comb begin
        case (ex_in.ls_size)
            LS_BYTE: byte_mask = 8'h01;
            LS_HALF: byte_mask = 8'h03;
            LS_WORD: byte_mask = 8'h0f;
            default: byte_mask = 8'hff;
        endcase
        byte_en = byte_mask << offset;
        for (int i = 0; i < 8; i++) begin
            write_mask[8*i +: 8] = {8{byte_en[i]}};   // byte enables to bit mask
        end
    end

    assign store_req = '{
        index:      ex_in.ls_address[`MEM_INDEX_LSB +: `MEM_INDEX_W],
        write_mask: write_mask,
        write_data: ex_in.store_data << {offset, 3'b000}
    };

    assign load_req = '{
        index:      ex_in.ls_address[`MEM_INDEX_LSB +: `MEM_INDEX_W],
        write_mask: '0,
        write_data: '0
    };

    // read data is only meaningful in the done cycle
    assign load_shifted = opload_read_data >> {offset, 3'b000};

    always_comb begin
        case (ex_in.ls_size)
            LS_BYTE: begin
                load_value = ex_in.is_unsigned ? {{(`XLEN-8){1'b0}}, load_shifted[7:0]}
                                               : {{(`XLEN-8){load_shifted[7]}}, load_shifted[7:0]};
            end
            LS_HALF: begin
                load_value = ex_in.is_unsigned ? {{(`XLEN-16){1'b0}}, load_shifted[15:0]}
                                               : {{(`XLEN-16){load_shifted[15]}}, load_shifted[15:0]};
            end
            LS_WORD: begin
                load_value = ex_in.is_unsigned ? {{(`XLEN-32){1'b0}}, load_shifted[31:0]}
                                               : {{(`XLEN-32){load_shifted[31]}}, load_shifted[31:0]};
            end
            default: load_value = load_shifted;
        endcase
    end

    assign mem_out = '{
        rd:         ex_in.rd,
        need_to_wb: ex_in.need_to_wb & ~ex_in.is_store,   // stores never write back
        result:     ex_in.is_load ? load_value : ex_in.alu_result
    };

    assign mem_byp = '{
        rd:         ex_in.rd,
        need_to_wb: mem_valid & mem_out.need_to_wb & (~ex_in.is_load | done_now),
        result:     mem_out.result
    };

    assign regfile_write_valid = wb_valid & wb_in.need_to_wb;

endmodule

//--- logic/backend.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module backend import backend_pkg::*; (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               pipeval,
    input  issue_t             issue,

    // writeback to the register file
    output logic               regfile_write_valid,
    output logic [`XLEN-1:0]   regfile_write_data,
    output logic [`LREG_W-1:0] regfile_write_rd,

    output logic               mem_stall,

    // store channel
    output logic               opstore_index_valid,
    input  logic               opstore_index_ready,
    output mem_req_t           store_req,
    input  logic               opstore_operation_done,

    // load channel
    output logic               opload_index_valid,
    input  logic               opload_index_ready,
    output mem_req_t           load_req,
    input  logic [`XLEN-1:0]   opload_read_data,
    input  logic               opload_operation_done,

    output logic               flop_commit_valid,
    output byp_t               ex_byp,
    output byp_t               mem_byp
);

    logic    mem_valid;
    logic    wb_valid;
    logic    ex_mem_en;
    logic    mem_busy;
    ex_mem_t ex_d;
    ex_mem_t ex_q;
    mem_wb_t wb_d;
    mem_wb_t wb_q;

    backend_ctrl u_ctrl (
        .clock             (clock),
        .reset_n           (reset_n),
        .pipeval           (pipeval),
        .mem_busy          (mem_busy),
        .mem_valid         (mem_valid),
        .wb_valid          (wb_valid),
        .ex_mem_en         (ex_mem_en),
        .mem_stall         (mem_stall),
        .flop_commit_valid (flop_commit_valid)
    );

    // the alu sees the valid of the instruction headed for the memory stage
    alu_unit u_alu (
        .issue     (issue),
        .mem_valid (pipeval),
        .ex_out    (ex_d),
        .ex_byp    (ex_byp)
    );

    stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clock   (clock),
        .reset_n (reset_n),
        .en      (ex_mem_en),
        .d       (ex_d),
        .q       (ex_q)
    );

    mem_stage u_mem (
        .clock                  (clock),
        .reset_n                (reset_n),
        .mem_valid              (mem_valid),
        .ex_in                  (ex_q),
        .wb_valid               (wb_valid),
        .wb_in                  (wb_q),
        .opload_index_ready     (opload_index_ready),
        .opload_read_data       (opload_read_data),
        .opload_operation_done  (opload_operation_done),
        .opstore_index_ready    (opstore_index_ready),
        .opstore_operation_done (opstore_operation_done),
        .mem_out                (wb_d),
        .mem_byp                (mem_byp),
        .mem_busy               (mem_busy),
        .opload_index_valid     (opload_index_valid),
        .opstore_index_valid    (opstore_index_valid),
        .load_req               (load_req),
        .store_req              (store_req),
        .regfile_write_valid    (regfile_write_valid)
    );

    // held along with ex_mem while wb_valid bubbles
    stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clock   (clock),
        .reset_n (reset_n),
        .en      (ex_mem_en),
        .d       (wb_d),
        .q       (wb_q)
    );

    assign regfile_write_data = wb_q.result;
    assign regfile_write_rd   = wb_q.rd;

endmodule

//--- verification/backend_chk.sv
`timescale 1ns/1ps

module backend_chk import backend_pkg::*; (
    input logic     clock,
    input logic     reset_n,
    input logic     mem_valid,
    input ex_mem_t  ex_in,
    input logic     mem_busy,
    input logic     opload_index_valid,
    input logic     opload_index_ready,
    input mem_req_t load_req,
    input logic     opstore_index_valid,
    input logic     opstore_index_ready,
    input mem_req_t store_req
);

    int unsigned fail_count = 0;

    // a request is held, unchanged, until ready
    load_held: assert property (@(posedge clock) disable iff (!reset_n)
        opload_index_valid && !opload_index_ready |=> opload_index_valid && $stable(load_req))
        else begin
            fail_count++;
            $error("load request dropped or changed before ready");
        end

    store_held: assert property (@(posedge clock) disable iff (!reset_n)
        opstore_index_valid && !opstore_index_ready |=> opstore_index_valid && $stable(store_req))
        else begin
            fail_count++;
            $error("store request dropped or changed before ready");
        end

    // a busy entry stays put until its access is done
    busy_needs_entry: assert property (@(posedge clock) disable iff (!reset_n)
        mem_busy |=> mem_valid && $stable(ex_in))
        else begin
            fail_count++;
            $error("memory stage entry dropped or changed while busy");
        end

    one_channel: assert property (@(posedge clock) disable iff (!reset_n)
        !(opload_index_valid && opstore_index_valid))
        else begin
            fail_count++;
            $error("load and store channels valid together");
        end

endmodule

bind mem_stage backend_chk u_chk (
    .clock               (clock),
    .reset_n             (reset_n),
    .mem_valid           (mem_valid),
    .ex_in               (ex_in),
    .mem_busy            (mem_busy),
    .opload_index_valid  (opload_index_valid),
    .opload_index_ready  (opload_index_ready),
    .load_req            (load_req),
    .opstore_index_valid (opstore_index_valid),
    .opstore_index_ready (opstore_index_ready),
    .store_req           (store_req)
);

//--- verification/backend_tb.sv
`timescale 1ns/1ps
`include "backend_cfg.svh"

module backend_tb import backend_pkg::*; ();

    typedef struct packed {
        logic                    is_load;
        logic [`MEM_INDEX_W-1:0] index;
        logic [`XLEN-1:0]        mask;
        logic [`XLEN-1:0]        data;
        logic [`XLEN-1:0]        value;   // extended load result
        logic                    need_to_wb;
    } access_t;

    typedef struct packed {
        logic [`LREG_W-1:0] rd;
        logic [`XLEN-1:0]   value;
    } write_t;

    localparam int N_INSTR         = 400;
    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = N_INSTR * 12;
    localparam logic [`XLEN-1:0] MEM_BASE = 64'h0000_0000_8000_2000;

    logic               clock;
    logic               reset_n;
    logic               pipeval;
    issue_t             issue;
    logic               regfile_write_valid;
    logic [`XLEN-1:0]   regfile_write_data;
    logic [`LREG_W-1:0] regfile_write_rd;
    logic               mem_stall;
    logic               opstore_index_valid;
    logic               opstore_index_ready;
    mem_req_t           store_req;
    logic               opstore_operation_done;
    logic               opload_index_valid;
    logic               opload_index_ready;
    mem_req_t           load_req;
    logic [`XLEN-1:0]   opload_read_data;
    logic               opload_operation_done;
    logic               flop_commit_valid;
    byp_t               ex_byp;
    byp_t               mem_byp;

    integer     seed;
    access_t    access_q[$];
    write_t     write_q[$];
    logic [`XLEN-1:0] ref_mem [logic [`MEM_INDEX_W-1:0]];    // model view
    logic [`XLEN-1:0] resp_mem [logic [`MEM_INDEX_W-1:0]];   // what the DUT wrote
    int         pending;   // loads/stores sitting in the memory stage
    int         commit_count;
    logic       byp_check;
    byp_t       byp_exp;
    write_t     wr_exp;
    issue_t     next_instr;
    logic [31:0] gap;

    backend u_backend (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [`XLEN-1:0] actual,
                               input logic [`XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // every index bit shows up in the word
    function automatic logic [`XLEN-1:0] fill_word(input logic [`MEM_INDEX_W-1:0] idx);
        return {idx, 13'h1a5, ~idx, 13'h0c3};
    endfunction

    function automatic int size_bytes(input ls_size_e s);
        case (s)
            LS_BYTE: return 1;
            LS_HALF: return 2;
            LS_WORD: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] ref_alu(input issue_t t);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        logic [31:0] r32;
        a = t.src1;
        b = t.is_imm ? t.imm : t.src2;
        if (t.is_word) begin
            case (t.alu_op)
                ALU_ADD: r32 = a[31:0] + b[31:0];
                ALU_SUB: r32 = a[31:0] - b[31:0];
                ALU_SLL: r32 = a[31:0] << b[4:0];
                ALU_SRL: r32 = a[31:0] >> b[4:0];
                ALU_SRA: r32 = $signed(a[31:0]) >>> b[4:0];
                default: r32 = 32'h0;
            endcase
            r = {{32{r32[31]}}, r32};
        end else begin
            case (t.alu_op)
                ALU_ADD:  r = a + b;
                ALU_SUB:  r = a - b;
                ALU_AND:  r = a & b;
                ALU_OR:   r = a | b;
                ALU_XOR:  r = a ^ b;
                ALU_SLL:  r = a << b[5:0];
                ALU_SRL:  r = a >> b[5:0];
                ALU_SRA:  r = $signed(a) >>> b[5:0];
                ALU_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                ALU_SLTU: r = (a < b) ? 64'd1 : 64'd0;
                default:  r = 64'h0;
            endcase
        end
        return r;
    endfunction

    task automatic make_instr(output issue_t t);
        logic [31:0] r;
        logic [31:0] kind;
        logic [63:0] addr;
        int          nb;
        t = '0;
        r = rand32();
        kind = r % 10;
        r = rand32();
        t.rd = r[4:0];
        t.imm = {{52{r[16]}}, r[16:5]};
        t.src1 = {rand32(), rand32()};
        t.src2 = {rand32(), rand32()};
        r = rand32();
        if (kind < 6) begin
            t.alu_op = alu_op_e'(4'(1 + r % 10));
            t.is_imm = r[8];
            // only add, sub and the shifts have word forms
            t.is_word = r[9] & r[10] & (t.alu_op inside {ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA});
            t.need_to_wb = (t.rd != 0);
        end else begin
            t.ls_size = ls_size_e'(4'b0001 << r[1:0]);
            nb = size_bytes(t.ls_size);
            addr = MEM_BASE + 64'({r[8:5], 3'b000}) + 64'((int'(r[4:2]) / nb) * nb);   // aligned
            t.is_unsigned = r[9];
            t.is_load = (kind < 8);
            t.is_store = (kind >= 8);
            t.alu_op = ALU_ADD;
            t.is_imm = 1'b1;
            t.src1 = addr - t.imm;
            t.need_to_wb = t.is_load && (t.rd != 0);
        end
    endtask

    task automatic send_instr(input issue_t t);
        logic [63:0]             alu_val;
        logic [63:0]             addr;
        logic [63:0]             word;
        logic [63:0]             mask;
        logic [63:0]             shifted;
        logic [63:0]             value;
        logic [`MEM_INDEX_W-1:0] idx;
        logic                    is_mem;
        int                      off;
        int                      nb;
        is_mem = t.is_load | t.is_store;
        alu_val = ref_alu(t);
        addr = t.src1 + t.imm;
        idx = addr[21:3];
        off = int'(addr[2:0]);
        nb = size_bytes(t.ls_size);
        word = ref_mem.exists(idx) ? ref_mem[idx] : fill_word(idx);
        for (int i = 0; i < 8; i++) begin
            mask[8*i +: 8] = (i >= off && i < off + nb) ? 8'hff : 8'h00;
        end
        shifted = t.src2 << (8 * off);
        value = word >> (8 * off);
        for (int i = 0; i < 64; i++) begin
            if (i >= 8 * nb) value[i] = t.is_unsigned ? 1'b0 : value[8*nb-1];
        end
        pipeval = 1'b1;
        issue = t;
        @(negedge clock);
        check_value("ex_byp.need_to_wb", ex_byp.need_to_wb, t.need_to_wb & ~is_mem);
        if (!is_mem) begin
            check_value("ex_byp.rd", ex_byp.rd, t.rd);
            check_value("ex_byp.result", ex_byp.result, alu_val);
        end
        while (mem_stall) @(negedge clock);
        @(posedge clock);
        #1;
        if (is_mem) begin
            access_q.push_back('{t.is_load, idx, mask, shifted, value, t.need_to_wb});
            pending++;
            if (t.is_store) ref_mem[idx] = (word & ~mask) | (shifted & mask);
        end else begin
            byp_exp = '{t.rd, t.need_to_wb, alu_val};
            byp_check = 1'b1;
        end
        if (t.need_to_wb) write_q.push_back('{t.rd, is_mem ? value : alu_val});
    endtask

    task automatic serve_access();
        access_t     exp;
        mem_req_t    req;
        logic        ld;
        logic [31:0] r;
        logic [63:0] word;
        ld = opload_index_valid;
        req = ld ? load_req : store_req;
        r = rand32();
        if (access_q.size() == 0) begin
            fail_run("memory request with no load or store in flight");
        end else begin
            exp = access_q.pop_front();
            check_value("opload_index_valid", ld, exp.is_load);
            check_value(ld ? "load_req.index" : "store_req.index", req.index, exp.index);
            if (!ld) begin
                check_value("store_req.write_mask", req.write_mask, exp.mask);
                check_value("store_req.write_data", req.write_data, exp.data);
            end
            word = resp_mem.exists(req.index) ? resp_mem[req.index] : fill_word(req.index);
            repeat (int'(r[1:0])) @(posedge clock);
            @(posedge clock);
            #1;
            if (ld) opload_index_ready = 1'b1;
            else opstore_index_ready = 1'b1;
            @(posedge clock);   // acceptance edge
            #1;
            opload_index_ready = 1'b0;
            opstore_index_ready = 1'b0;
            repeat (int'(r[5:4])) begin
                @(posedge clock);
                #1;
            end
            if (ld) begin
                opload_read_data = word;
                opload_operation_done = 1'b1;
            end else begin
                resp_mem[req.index] = (word & ~req.write_mask) | (req.write_data & req.write_mask);
                opstore_operation_done = 1'b1;
            end
            @(negedge clock);
            if (ld) begin
                check_value("mem_byp.need_to_wb", mem_byp.need_to_wb, exp.need_to_wb);
                check_value("mem_byp.result", mem_byp.result, exp.value);
            end
            @(posedge clock);
            #1;
            opload_operation_done = 1'b0;
            opstore_operation_done = 1'b0;
            opload_read_data = '0;
            pending--;
        end
    endtask

    initial begin
        @(posedge reset_n);
        forever begin
            @(negedge clock);
            if (opload_index_valid || opstore_index_valid) serve_access();
        end
    end

    always @(negedge clock) begin
        if (reset_n) begin
            check_value("mem_stall", mem_stall,
                        (pending != 0) && !(opload_operation_done || opstore_operation_done));
            if (pending != 0 && !opload_operation_done) begin
                check_value("mem_byp.need_to_wb", mem_byp.need_to_wb, 1'b0);
            end
            if (byp_check) begin
                check_value("mem_byp.rd", mem_byp.rd, byp_exp.rd);
                check_value("mem_byp.need_to_wb", mem_byp.need_to_wb, byp_exp.need_to_wb);
                check_value("mem_byp.result", mem_byp.result, byp_exp.result);
                byp_check = 1'b0;
            end
            if (regfile_write_valid) begin
                if (write_q.size() == 0) begin
                    fail_run("register write with no instruction expecting one");
                end else begin
                    wr_exp = write_q.pop_front();
                    check_value("regfile_write_rd", regfile_write_rd, wr_exp.rd);
                    check_value("regfile_write_data", regfile_write_data, wr_exp.value);
                end
            end
            if (flop_commit_valid) commit_count++;
        end
    end

    // stop as soon as a bound assertion fires
    always @(u_backend.u_mem.u_chk.fail_count) begin
        if (u_backend.u_mem.u_chk.fail_count != 0) begin
            fail_run("a memory channel assertion failed");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("timeout, the instruction stream did not drain in time");
    end

    initial begin
        seed = 32'ha130d211;
        clock = 1'b0;
        reset_n = 1'b0;
        pipeval = 1'b0;
        issue = '0;
        opstore_index_ready = 1'b0;
        opstore_operation_done = 1'b0;
        opload_index_ready = 1'b0;
        opload_operation_done = 1'b0;
        opload_read_data = '0;
        pending = 0;
        commit_count = 0;
        byp_check = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        check_value("regfile_write_valid", regfile_write_valid, 1'b0);
        check_value("opload_index_valid", opload_index_valid, 1'b0);
        check_value("opstore_index_valid", opstore_index_valid, 1'b0);
        check_value("mem_stall", mem_stall, 1'b0);
        check_value("flop_commit_valid", flop_commit_valid, 1'b0);
        @(posedge clock);
        #1;
        reset_n = 1'b1;
        for (int n = 0; n < N_INSTR; n++) begin
            make_instr(next_instr);
            gap = rand32();
            if (gap[1:0] == 2'b00) begin   // occasional bubble
                pipeval = 1'b0;
                @(posedge clock);
                #1;
            end
            send_instr(next_instr);
        end
        pipeval = 1'b0;
        issue = '0;
        wait (commit_count == N_INSTR);
        repeat (4) @(negedge clock);
        check_value("commit pulses", commit_count, N_INSTR);
        check_value("register writes outstanding", write_q.size(), 0);
        check_value("memory accesses outstanding", access_q.size(), 0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- backend.f
+incdir+logic
logic/backend_pkg.sv
logic/stage_reg.sv
logic/backend_ctrl.sv
logic/alu_unit.sv
logic/mem_stage.sv
logic/backend.sv
verification/backend_chk.sv
verification/backend_tb.sv

//--- Bender.yml
package:
  name: backend

sources:
  - include_dirs:
      - logic
    files:
      - logic/backend_pkg.sv
      - logic/stage_reg.sv
      - logic/backend_ctrl.sv
      - logic/alu_unit.sv
      - logic/mem_stage.sv
      - logic/backend.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/backend_chk.sv
      - verification/backend_tb.sv
